//--- include/pool_macros.svh
`ifndef POOL_MACROS_SVH
`define POOL_MACROS_SVH

// Four signed lanes per memory word
`define POOL_LANES 4
`define POOL_LANE_W 8

// Memory and output buffer address width
`define POOL_ADDR_W 8

// Geometry and job length inputs
`define POOL_CNT_W 16

`endif

//--- verilog/pool_data_pkg.sv
`include "pool_macros.svh"

package pool_data_pkg;

	// One activation value
	typedef logic signed [`POOL_LANE_W-1:0] lane_t;

	typedef logic [`POOL_LANES*`POOL_LANE_W-1:0] word_t; // Lane 0 in the low bits

	typedef logic [`POOL_ADDR_W-1:0] addr_t;

endpackage

//--- verilog/pool_ctrl_pkg.sv
`include "pool_macros.svh"

package pool_ctrl_pkg;

	typedef logic [`POOL_CNT_W-1:0] count_t; // Row length and output word count

	// Only POOL_1D and POOL_2D start a job
	typedef enum logic [2:0] {
		POOL_NONE = 3'd0,
		POOL_1D   = 3'd1,
		POOL_2D   = 3'd2
	} pool_mode_t;

	typedef enum logic [3:0] {
		IDLE,
		P1_PRE_READ,
		P1_READ,
		P1_OPERATE,
		P1_WRITE,
		P2_PRE_READ,
		P2_READ_ROW1,
		P2_OPERATE,
		P2_WRITE
	} pool_state_t;

endpackage

//--- verilog/pool_fsm.sv
`timescale 1ns/100ps

module pool_fsm (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    enable,
	input  pool_ctrl_pkg::pool_mode_t mode,
	input  logic                    last_slot,
	input  logic                    last_word,
	output pool_ctrl_pkg::pool_mode_t job_mode,
	output logic                    clear,
	output logic                    capture,
	output logic                    row1_sel,
	output logic                    step,
	output logic                    write,
	output logic                    rd_en,
	output logic                    wr_en,
	output logic                    done
);
	import pool_ctrl_pkg::*;

	pool_state_t state;
	pool_state_t state_next;
	logic        start;

	assign start = enable && (mode == POOL_1D || mode == POOL_2D);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state    <= IDLE;
			job_mode <= POOL_NONE;
		end else begin
			state <= state_next;
			if (state == IDLE && start)
				job_mode <= mode; // Held for the whole job
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE:
				if (start)
					state_next = (mode == POOL_1D) ? P1_PRE_READ : P2_PRE_READ;
			P1_PRE_READ:  state_next = P1_READ;
			P1_READ:      state_next = P1_OPERATE;
			P1_OPERATE:   state_next = last_slot ? P1_WRITE : P1_PRE_READ;
			P1_WRITE:     state_next = last_word ? IDLE : P1_PRE_READ;
			P2_PRE_READ:  state_next = P2_READ_ROW1;
			P2_READ_ROW1: state_next = P2_OPERATE;
			P2_OPERATE:   state_next = last_slot ? P2_WRITE : P2_PRE_READ;
			P2_WRITE:     state_next = last_word ? IDLE : P2_PRE_READ;
			default:      state_next = IDLE;
		endcase
		// Abort from any active state
		if (!enable && state != IDLE)
			state_next = IDLE;
	end

	assign clear    = (state == IDLE);
	assign capture  = (state == P1_READ) || (state == P2_READ_ROW1);
	assign row1_sel = (state == P2_READ_ROW1);
	assign step     = (state == P1_OPERATE) || (state == P2_OPERATE);
	assign write    = (state == P1_WRITE) || (state == P2_WRITE);
	// 1D repeats the address in READ, 2D fetches the row below
	assign rd_en    = (state == P1_PRE_READ) || (state == P1_READ) ||
			  (state == P2_PRE_READ) || (state == P2_READ_ROW1);
	assign wr_en    = write;
	assign done     = write && last_word;

endmodule

//--- verilog/pool_addr_counter.sv
`timescale 1ns/100ps
`include "pool_macros.svh"

module pool_addr_counter (
	input  logic                      clk,
	input  logic                      reset,
	input  pool_ctrl_pkg::pool_mode_t job_mode,
	input  pool_ctrl_pkg::count_t     row_len,
	input  pool_ctrl_pkg::count_t     out_words,
	input  logic                      clear,
	input  logic                      row1_sel,
	input  logic                      step,
	input  logic                      write,
	output pool_data_pkg::addr_t      rd_addr,
	output pool_data_pkg::addr_t      wr_addr,
	output logic [1:0]                slot,
	output logic                      last_slot,
	output logic                      last_word
);
	import pool_data_pkg::*;
	import pool_ctrl_pkg::*;

	addr_t  base;     // Read address of the current row 0 word
	addr_t  row_off;
	count_t col;
	count_t out_cnt;
	logic   last_col;

	assign row_off  = row_len[`POOL_ADDR_W-1:0];
	assign last_col = (col == row_len - count_t'(1));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			base    <= '0;
			col     <= '0;
			slot    <= '0;
			wr_addr <= '0;
			out_cnt <= '0;
		end else if (clear) begin
			base    <= '0;
			col     <= '0;
			slot    <= '0;
			wr_addr <= '0;
			out_cnt <= '0;
		end else begin
			if (step) begin
				slot <= last_slot ? 2'd0 : slot + 2'd1;
				if (job_mode == POOL_2D) begin
					if (last_col) begin
						// Skip over the row already used as row 1
						col  <= '0;
						base <= base + row_off + addr_t'(1);
					end else begin
						col  <= col + count_t'(1);
						base <= base + addr_t'(1);
					end
				end else begin
					base <= base + addr_t'(1);
				end
			end
			if (write) begin
				wr_addr <= wr_addr + addr_t'(1);
				out_cnt <= out_cnt + count_t'(1);
			end
		end
	end

	// Four words per output in 1D, two pairs in 2D
	assign last_slot = (job_mode == POOL_2D) ? (slot == 2'd1) : (slot == 2'd3);
	assign last_word = (out_cnt == out_words - count_t'(1));

	assign rd_addr = row1_sel ? base + row_off : base;

endmodule

//--- verilog/pool_reduce.sv
`timescale 1ns/100ps
`include "pool_macros.svh"

module pool_reduce (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      capture,
	input  pool_ctrl_pkg::pool_mode_t job_mode,
	input  pool_data_pkg::word_t      read_word,
	output pool_data_pkg::lane_t      max_lo,
	output pool_data_pkg::lane_t      max_hi
);
	import pool_data_pkg::*;
	import pool_ctrl_pkg::*;

	word_t held; // Row 0 word in 2D, the only word in 1D
	lane_t held_lo;
	lane_t held_hi;
	lane_t rd_lo;
	lane_t rd_hi;

	function automatic lane_t smax(input lane_t a, input lane_t b);
		return (a >= b) ? a : b;
	endfunction

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			held <= '0;
		else if (capture)
			held <= read_word;
	end

	// Pairwise maxima over lanes 0/1 and 2/3
	assign held_lo = smax(held[0*`POOL_LANE_W +: `POOL_LANE_W],
			      held[1*`POOL_LANE_W +: `POOL_LANE_W]);
	assign held_hi = smax(held[2*`POOL_LANE_W +: `POOL_LANE_W],
			      held[3*`POOL_LANE_W +: `POOL_LANE_W]);
	assign rd_lo   = smax(read_word[0*`POOL_LANE_W +: `POOL_LANE_W],
			      read_word[1*`POOL_LANE_W +: `POOL_LANE_W]);
	assign rd_hi   = smax(read_word[2*`POOL_LANE_W +: `POOL_LANE_W],
			      read_word[3*`POOL_LANE_W +: `POOL_LANE_W]);

	always_comb begin
		if (job_mode == POOL_2D) begin
			max_lo = smax(held_lo, rd_lo); // Left 2x2 window
			max_hi = smax(held_hi, rd_hi);
		end else begin
			max_lo = smax(held_lo, held_hi);
			max_hi = held_hi;
		end
	end

endmodule

//--- verilog/pool_assemble.sv
`timescale 1ns/100ps
`include "pool_macros.svh"

module pool_assemble (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      clear,
	input  logic                      step,
	input  pool_ctrl_pkg::pool_mode_t job_mode,
	input  logic [1:0]                slot,
	input  pool_data_pkg::lane_t      max_lo,
	input  pool_data_pkg::lane_t      max_hi,
	output pool_data_pkg::word_t      output_word
);
	import pool_ctrl_pkg::*;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			output_word <= '0;
		end else if (clear) begin
			output_word <= '0;
		end else if (step) begin
			if (job_mode == POOL_2D)
				// Slot picks the lane pair for the two windows
				output_word[slot*2*`POOL_LANE_W +: 2*`POOL_LANE_W] <= {max_hi, max_lo};
			else
				output_word[slot*`POOL_LANE_W +: `POOL_LANE_W] <= max_lo;
		end
	end

endmodule

//--- verilog/pooling_top.sv
`timescale 1ns/100ps

module pooling_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      enable,
	input  pool_ctrl_pkg::pool_mode_t mode,
	input  pool_ctrl_pkg::count_t     row_len,
	input  pool_ctrl_pkg::count_t     out_words,
	input  pool_data_pkg::word_t      read_word,
	output pool_data_pkg::addr_t      rd_addr,
	output logic                      rd_en,
	output logic                      wr_en,
	output pool_data_pkg::addr_t      wr_addr,
	output pool_data_pkg::word_t      output_word,
	output logic                      done
);
	import pool_data_pkg::*;
	import pool_ctrl_pkg::*;

	pool_mode_t job_mode;
	logic       clear;
	logic       capture;
	logic       row1_sel;
	logic       step;
	logic       write;
	logic [1:0] slot;
	logic       last_slot;
	logic       last_word;
	lane_t      max_lo;
	lane_t      max_hi;

	pool_fsm u_fsm (
		.clk       (clk),
		.reset     (reset),
		.enable    (enable),
		.mode      (mode),
		.last_slot (last_slot),
		.last_word (last_word),
		.job_mode  (job_mode),
		.clear     (clear),
		.capture   (capture),
		.row1_sel  (row1_sel),
		.step      (step),
		.write     (write),
		.rd_en     (rd_en),
		.wr_en     (wr_en),
		.done      (done)
	);

	pool_addr_counter u_addr_counter (
		.clk       (clk),
		.reset     (reset),
		.job_mode  (job_mode),
		.row_len   (row_len),
		.out_words (out_words),
		.clear     (clear),
		.row1_sel  (row1_sel),
		.step      (step),
		.write     (write),
		.rd_addr   (rd_addr),
		.wr_addr   (wr_addr),
		.slot      (slot),
		.last_slot (last_slot),
		.last_word (last_word)
	);

	pool_reduce u_reduce (
		.clk       (clk),
		.reset     (reset),
		.capture   (capture),
		.job_mode  (job_mode),
		.read_word (read_word),
		.max_lo    (max_lo),
		.max_hi    (max_hi)
	);

	pool_assemble u_assemble (
		.clk         (clk),
		.reset       (reset),
		.clear       (clear),
		.step        (step),
		.job_mode    (job_mode),
		.slot        (slot),
		.max_lo      (max_lo),
		.max_hi      (max_hi),
		.output_word (output_word)
	);

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #20 clk = ~clk; // 40 ns period

endmodule

//--- sim/tb_pooling_top.sv
`timescale 1ns/100ps
`include "pool_macros.svh"

module tb_pooling_top;
	import pool_data_pkg::*;
	import pool_ctrl_pkg::*;

	// Reset window, 1D job, 2D job, bad mode, abort and restart, tail
	localparam int run_cycles = 6 + (3*13 + 3) + (3*7 + 3) + 22 + (26 + 2*7 + 3) + 4;

	logic       clk;
	logic       reset;
	logic       enable;
	pool_mode_t mode;
	count_t     row_len;
	count_t     out_words;
	word_t      read_word;
	addr_t      rd_addr;
	logic       rd_en;
	logic       wr_en;
	addr_t      wr_addr;
	word_t      output_word;
	logic       done;

	word_t mem [0:255];
	word_t exp_words [0:15];
	addr_t exp_rd [0:63];
	logic  mem_hit;
	addr_t mem_addr;
	logic  mark;             // High in the start cycle of a job
	logic  zero_chk;
	logic  quiet_chk;
	logic  en_low_prev = 1'b0;
	int    since_ev = 0;
	int    wr_idx = 0;
	int    rd_idx = 0;
	int    cur_words;
	int    exp_gap;
	int    mismatch_cnt = 0;
	int    fail_cnt = 0;

	tb_clock u_clock (.clk(clk));

	pooling_top u_pooling_top (
		.clk(clk), .reset(reset), .enable(enable), .mode(mode),
		.row_len(row_len), .out_words(out_words), .read_word(read_word),
		.rd_addr(rd_addr), .rd_en(rd_en), .wr_en(wr_en), .wr_addr(wr_addr),
		.output_word(output_word), .done(done)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic lane_t lane_of(input word_t w, input int k);
		return lane_t'(w[k*`POOL_LANE_W +: `POOL_LANE_W]);
	endfunction

	function automatic lane_t max4(input lane_t a, input lane_t b, input lane_t c,
			input lane_t d);
		lane_t m;
		m = a;
		if (b > m)
			m = b;
		if (c > m)
			m = c;
		if (d > m)
			m = d;
		return m;
	endfunction

	// Expected output words and read address sequence for one job
	task automatic build_job(input pool_mode_t m, input int rl, input int nw);
		int    p;
		int    base;
		int    col;
		word_t w0;
		word_t w1;
		base = 0;
		col = 0;
		for (p = 0; p < nw; p++)
			exp_words[p] = '0;
		if (m == POOL_1D) begin
			for (p = 0; p < 4*nw; p++) begin
				w0 = mem[p % 256];
				exp_rd[2*p] = addr_t'(p);
				exp_rd[2*p+1] = addr_t'(p); // Address repeated in READ
				exp_words[p/4][(p%4)*`POOL_LANE_W +: `POOL_LANE_W] =
					max4(lane_of(w0, 0), lane_of(w0, 1), lane_of(w0, 2), lane_of(w0, 3));
			end
		end else begin
			for (p = 0; p < 2*nw; p++) begin
				w0 = mem[base % 256];
				w1 = mem[(base + rl) % 256];
				exp_rd[2*p] = addr_t'(base);
				exp_rd[2*p+1] = addr_t'(base + rl);
				exp_words[p/2][(p%2)*2*`POOL_LANE_W +: 2*`POOL_LANE_W] = {
					max4(lane_of(w0, 2), lane_of(w0, 3), lane_of(w1, 2), lane_of(w1, 3)),
					max4(lane_of(w0, 0), lane_of(w0, 1), lane_of(w1, 0), lane_of(w1, 1))};
				if (col == rl - 1) begin
					col = 0;
					base = base + rl + 1; // Skip the row below
				end else begin
					col++;
					base++;
				end
			end
		end
	endtask

	task automatic start_job(input pool_mode_t m, input int rl, input int nw, input int gap);
		@(posedge clk);
		#2;
		enable = 1'b1;
		mode = m;
		row_len = count_t'(rl);
		out_words = count_t'(nw);
		cur_words = nw;
		exp_gap = gap;
		mark = 1'b1;
		@(posedge clk);
		#2 mark = 1'b0;
	endtask

	task automatic finish_job(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (!done && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!done) begin
			fail_cnt++;
			$display("job did not raise done within %0d cycles", limit);
		end
		@(posedge clk);
		#2 enable = 1'b0; // Leave IDLE without a restart
	endtask

	task automatic run_job(input pool_mode_t m, input int rl, input int nw, input int gap);
		build_job(m, rl, nw);
		start_job(m, rl, nw, gap);
		finish_job(nw*gap + 4);
	endtask

	// Memory answers one cycle after the read
	always @(posedge clk) begin
		mem_hit = rd_en;
		mem_addr = rd_addr;
		#2;
		if (mem_hit)
			read_word = mem[mem_addr];
	end

	always @(posedge clk) begin
		if (mark) begin
			since_ev <= 1;
			wr_idx <= 0;
			rd_idx <= 0;
		end else begin
			since_ev <= wr_en ? 1 : since_ev + 1;
			if (wr_en)
				wr_idx <= wr_idx + 1;
			if (rd_en)
				rd_idx <= rd_idx + 1;
		end
		en_low_prev <= !enable;
	end

	assert property (@(posedge clk) (!reset || zero_chk) |->
			(rd_addr == '0 && wr_addr == '0 && output_word == '0))
		else begin
			mismatch_cnt++;
			$display("mismatch rd_addr/wr_addr/output_word: got %h %h %h expected 0",
				$sampled(rd_addr), $sampled(wr_addr), $sampled(output_word));
		end

	assert property (@(posedge clk) (!reset || zero_chk || quiet_chk) |->
			(!rd_en && !wr_en && !done))
		else begin
			fail_cnt++;
			$display("engine issued a read, write or done while it should be idle");
		end

	assert property (@(posedge clk) rd_en |-> rd_addr == exp_rd[rd_idx])
		else begin
			mismatch_cnt++;
			$display("mismatch rd_addr: got %h expected %h", $sampled(rd_addr),
				exp_rd[$sampled(rd_idx)]);
		end

	assert property (@(posedge clk) wr_en |-> wr_addr == addr_t'(wr_idx))
		else begin
			mismatch_cnt++;
			$display("mismatch wr_addr: got %h expected %h", $sampled(wr_addr),
				$sampled(wr_idx));
		end

	assert property (@(posedge clk) wr_en |-> output_word == exp_words[wr_idx])
		else begin
			mismatch_cnt++;
			$display("mismatch output_word: got %h expected %h", $sampled(output_word),
				exp_words[$sampled(wr_idx)]);
		end

	assert property (@(posedge clk) wr_en |-> since_ev == exp_gap)
		else begin
			mismatch_cnt++;
			$display("mismatch wr_en spacing: got %h expected %h", $sampled(since_ev),
				$sampled(exp_gap));
		end

	assert property (@(posedge clk) (done || (wr_en && wr_idx == cur_words - 1)) |->
			(done && wr_en && wr_idx == cur_words - 1))
		else begin
			fail_cnt++;
			$display("done did not coincide with the last write of the job");
		end

	assert property (@(posedge clk) (!enable && en_low_prev) |-> (!rd_en && !wr_en))
		else begin
			fail_cnt++;
			$display("read or write issued after enable was dropped");
		end

	initial begin
		#(2 * run_cycles * 40);
		$display("watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] seed;
		reset = 1'b1;
		enable = 1'b0;
		mode = POOL_NONE;
		row_len = '0;
		out_words = '0;
		read_word = '0;
		mark = 1'b0;
		zero_chk = 1'b1;
		quiet_chk = 1'b1;
		cur_words = 0;
		exp_gap = 0;
		seed = 32'hc43b;
		for (int i = 0; i < 256; i++) begin
			seed = lcg_next(seed);
			mem[i] = seed;
		end
		#2 reset = 1'b0;
		repeat (3) @(posedge clk);
		#2 reset = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		zero_chk = 1'b0;
		quiet_chk = 1'b0;
		run_job(POOL_1D, 3, 3, 13);
		run_job(POOL_2D, 3, 3, 7);
		// Code 3 is not a pooling job
		@(posedge clk);
		#2;
		enable = 1'b1;
		mode = pool_mode_t'(3'd3);
		quiet_chk = 1'b1;
		repeat (20) @(posedge clk);
		#2;
		enable = 1'b0;
		quiet_chk = 1'b0;
		build_job(POOL_1D, 3, 3);
		start_job(POOL_1D, 3, 3, 13);
		repeat (20) @(posedge clk); // Inside the second output word
		#2 enable = 1'b0;
		repeat (4) @(posedge clk);
		run_job(POOL_2D, 2, 2, 7);
		repeat (2) @(posedge clk);
		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- pooling_top.f
+incdir+include
verilog/pool_data_pkg.sv
verilog/pool_ctrl_pkg.sv
verilog/pool_fsm.sv
verilog/pool_addr_counter.sv
verilog/pool_reduce.sv
verilog/pool_assemble.sv
verilog/pooling_top.sv
sim/tb_clock.sv
sim/tb_pooling_top.sv
